// ==== window_pkg.sv ====
/*
  shared types for the 3x3 window filter
  pixel width is fixed here and is not a module parameter
*/
`default_nettype none

package window_pkg;

  localparam int pixel_w = 8;

  // one grey-level sample
  typedef logic [pixel_w-1:0] pixel_t;

  // operation select, captured with every pixel
  typedef enum logic [1:0] {
    op_pass,
    op_smooth,
    op_sobel
  } filter_op_e;

  // input four-phase link
  typedef enum logic [1:0] {
    rx_idle,
    rx_ack,
    rx_drop
  } rx_state_e;

  // output four-phase link
  typedef enum logic [1:0] {
    tx_idle,
    tx_req,
    tx_drop
  } tx_state_e;

endpackage

`default_nettype wire

// ==== pixel_rx.sv ====
/*
  input side of the filter: four-phase req/ack, one pixel per transfer
  in_sof puts its pixel at column 0, row 0; there is no frame height
  line_width must be at least 3; the row count saturates at 2
*/
`timescale 1ns/1ns
`default_nettype none

module pixel_rx #(
  parameter int line_width = 320
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          in_req,
  input  wire                          in_sof,
  input  wire window_pkg::pixel_t      in_data,
  input  wire window_pkg::filter_op_e  in_op,
  input  wire                          busy,
  output logic                         in_ack,
  output logic                         advance,
  output window_pkg::pixel_t           pix,
  output logic [$clog2(line_width)-1:0] col,
  output window_pkg::filter_op_e       op,
  output logic                         win_ok
);

  localparam int col_w = $clog2(line_width);

  window_pkg::rx_state_e state;
  logic [col_w-1:0]      col_cnt;
  logic [1:0]            row_cnt;
  logic [col_w-1:0]      pos_col;
  logic [1:0]            pos_row;
  logic                  accept;
  logic                  last_col;

  // a pending result blocks the next transfer
  assign accept   = (state == window_pkg::rx_idle) && in_req && !busy;
  assign pos_col  = in_sof ? '0 : col_cnt;
  assign pos_row  = in_sof ? 2'd0 : row_cnt;
  assign last_col = (pos_col == col_w'(line_width - 1));
  assign in_ack   = (state == window_pkg::rx_ack);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= window_pkg::rx_idle;
    end else begin
      case (state)
        window_pkg::rx_idle: begin
          if (accept) begin
            state <= window_pkg::rx_ack;
          end
        end
        window_pkg::rx_ack: begin
          if (!in_req) begin
            state <= window_pkg::rx_drop;
          end
        end
        // one turnaround cycle with ack low
        default: state <= window_pkg::rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= 2'd0;
      advance <= 1'b0;
      win_ok  <= 1'b0;
    end else begin
      advance <= accept;
      win_ok  <= accept && (pos_col >= col_w'(2)) && (pos_row == 2'd2);
      if (accept) begin
        if (last_col) begin
          col_cnt <= '0;
          // rows 0, 1 and "2 or more" are all that matter
          row_cnt <= (pos_row == 2'd2) ? pos_row : pos_row + 2'd1;
        end else begin
          col_cnt <= pos_col + 1'b1;
          row_cnt <= pos_row;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pix <= in_data;
      col <= pos_col;
      op  <= in_op;
    end
  end

endmodule

`default_nettype wire

// ==== line_buffer.sv ====
/*
  one image row of delay, line_width entries addressed by column
  dout shows the stored entry at col; the advance edge that samples it
  also overwrites that entry with din (read before write)
*/
`timescale 1ns/1ns
`default_nettype none

module line_buffer #(
  parameter int line_width = 320
) (
  input  wire                            clk,
  input  wire                            advance,
  input  wire [$clog2(line_width)-1:0]   col,
  input  wire window_pkg::pixel_t        din,
  output window_pkg::pixel_t             dout
);

  window_pkg::pixel_t mem [line_width];

  // same column, one row earlier
  assign dout = mem[col];

  always_ff @(posedge clk) begin
    if (advance) begin
      mem[col] <= din;
    end
  end

endmodule

`default_nettype wire

// ==== line_window.sv ====
/*
  3x3 window assembly from two chained line buffers
  row 0 is two rows up, row 2 is the current row; column 2 is the newest
  window contents are only meaningful when win_ready pulses
*/
`timescale 1ns/1ns
`default_nettype none

module line_window #(
  parameter int line_width = 320
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            advance,
  input  wire [$clog2(line_width)-1:0]   col,
  input  wire window_pkg::pixel_t        pix,
  input  wire window_pkg::filter_op_e    op,
  input  wire                            win_ok,
  output window_pkg::pixel_t             w00,
  output window_pkg::pixel_t             w01,
  output window_pkg::pixel_t             w02,
  output window_pkg::pixel_t             w10,
  output window_pkg::pixel_t             w11,
  output window_pkg::pixel_t             w12,
  output window_pkg::pixel_t             w20,
  output window_pkg::pixel_t             w21,
  output window_pkg::pixel_t             w22,
  output window_pkg::filter_op_e         win_op,
  output logic                           win_ready
);

  window_pkg::pixel_t up1;
  window_pkg::pixel_t up2;

  line_buffer #(
    .line_width(line_width)
  ) u_line_1 (
    .clk    (clk),
    .advance(advance),
    .col    (col),
    .din    (pix),
    .dout   (up1)
  );

  // second row of delay is fed from the first
  line_buffer #(
    .line_width(line_width)
  ) u_line_2 (
    .clk    (clk),
    .advance(advance),
    .col    (col),
    .din    (up1),
    .dout   (up2)
  );

  always_ff @(posedge clk) begin
    if (advance) begin
      w00    <= w01;
      w01    <= w02;
      w02    <= up2;
      w10    <= w11;
      w11    <= w12;
      w12    <= up1;
      w20    <= w21;
      w21    <= w22;
      w22    <= pix;
      win_op <= op;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_ready <= 1'b0;
    end else begin
      win_ready <= advance && win_ok;
    end
  end

endmodule

`default_nettype wire

// ==== window_op.sv ====
/*
  computes the selected operation on a complete window and sends it out
  over a four-phase req/ack link; one result in flight at a time
  smooth truncates the weighted sum, sobel saturates at 255
*/
`timescale 1ns/1ns
`default_nettype none

module window_op (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire window_pkg::pixel_t      w00,
  input  wire window_pkg::pixel_t      w01,
  input  wire window_pkg::pixel_t      w02,
  input  wire window_pkg::pixel_t      w10,
  input  wire window_pkg::pixel_t      w11,
  input  wire window_pkg::pixel_t      w12,
  input  wire window_pkg::pixel_t      w20,
  input  wire window_pkg::pixel_t      w21,
  input  wire window_pkg::pixel_t      w22,
  input  wire window_pkg::filter_op_e  win_op,
  input  wire                          win_ready,
  input  wire                          out_ack,
  output logic                         out_req,
  output window_pkg::pixel_t           out_data,
  output logic                         busy
);

  window_pkg::tx_state_e state;
  window_pkg::pixel_t    result;
  logic [11:0]           smooth_sum;
  logic [9:0]            left_sum;
  logic [9:0]            right_sum;
  logic [9:0]            top_sum;
  logic [9:0]            bottom_sum;
  logic [9:0]            gx_abs;
  logic [9:0]            gy_abs;
  logic [10:0]           mag;

  // 1-2-1 by 1-2-1 kernel, weights sum to 16
  assign smooth_sum = {4'b0, w00} + {3'b0, w01, 1'b0} + {4'b0, w02}
                    + {3'b0, w10, 1'b0} + {2'b0, w11, 2'b0} + {3'b0, w12, 1'b0}
                    + {4'b0, w20} + {3'b0, w21, 1'b0} + {4'b0, w22};

  // column and row sums with weights 1 2 1
  assign left_sum   = {2'b0, w00} + {1'b0, w10, 1'b0} + {2'b0, w20};
  assign right_sum  = {2'b0, w02} + {1'b0, w12, 1'b0} + {2'b0, w22};
  assign top_sum    = {2'b0, w00} + {1'b0, w01, 1'b0} + {2'b0, w02};
  assign bottom_sum = {2'b0, w20} + {1'b0, w21, 1'b0} + {2'b0, w22};

  assign gx_abs = (right_sum >= left_sum) ? right_sum - left_sum : left_sum - right_sum;
  assign gy_abs = (bottom_sum >= top_sum) ? bottom_sum - top_sum : top_sum - bottom_sum;
  assign mag    = {1'b0, gx_abs} + {1'b0, gy_abs};

  always_comb begin
    case (win_op)
      window_pkg::op_smooth: result = smooth_sum[11:4];
      window_pkg::op_sobel:  result = (mag > 11'd255) ? '1 : mag[7:0];
      window_pkg::op_pass:   result = w11;
      default:               result = w11;
    endcase
  end

  // held from the window pulse until the handshake has finished
  assign busy    = win_ready || (state != window_pkg::tx_idle);
  assign out_req = (state == window_pkg::tx_req);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= window_pkg::tx_idle;
    end else begin
      case (state)
        window_pkg::tx_idle: begin
          if (win_ready) begin
            state <= window_pkg::tx_req;
          end
        end
        window_pkg::tx_req: begin
          if (out_ack) begin
            state <= window_pkg::tx_drop;
          end
        end
        // wait for the receiver to release ack
        default: begin
          if (!out_ack) begin
            state <= window_pkg::tx_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (win_ready && (state == window_pkg::tx_idle)) begin
      out_data <= result;
    end
  end

endmodule

`default_nettype wire

// ==== window_filter_top.sv ====
/*
  streaming 3x3 filter: input link, two-row line buffer, operation and
  output link; line_width sets the image row length (at least 3)
*/
`timescale 1ns/1ns
`default_nettype none

module window_filter_top #(
  parameter int line_width = 320
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          in_req,
  input  wire                          in_sof,
  input  wire window_pkg::pixel_t      in_data,
  input  wire window_pkg::filter_op_e  in_op,
  input  wire                          out_ack,
  output logic                         in_ack,
  output logic                         out_req,
  output window_pkg::pixel_t           out_data
);

  logic                          advance;
  logic                          win_ok;
  logic                          busy;
  logic                          win_ready;
  logic [$clog2(line_width)-1:0] col;
  window_pkg::pixel_t            pix;
  window_pkg::filter_op_e        op;
  window_pkg::filter_op_e        win_op;
  window_pkg::pixel_t            w00, w01, w02;
  window_pkg::pixel_t            w10, w11, w12;
  window_pkg::pixel_t            w20, w21, w22;

  pixel_rx #(
    .line_width(line_width)
  ) u_rx (
    .clk(clk), .rst_n(rst_n),
    .in_req(in_req), .in_sof(in_sof), .in_data(in_data), .in_op(in_op),
    .busy(busy), .in_ack(in_ack),
    .advance(advance), .pix(pix), .col(col), .op(op), .win_ok(win_ok)
  );

  line_window #(
    .line_width(line_width)
  ) u_window (
    .clk(clk), .rst_n(rst_n),
    .advance(advance), .col(col), .pix(pix), .op(op), .win_ok(win_ok),
    .w00(w00), .w01(w01), .w02(w02),
    .w10(w10), .w11(w11), .w12(w12),
    .w20(w20), .w21(w21), .w22(w22),
    .win_op(win_op), .win_ready(win_ready)
  );

  window_op u_op (
    .clk(clk), .rst_n(rst_n),
    .w00(w00), .w01(w01), .w02(w02),
    .w10(w10), .w11(w11), .w12(w12),
    .w20(w20), .w21(w21), .w22(w22),
    .win_op(win_op), .win_ready(win_ready), .out_ack(out_ack),
    .out_req(out_req), .out_data(out_data), .busy(busy)
  );

endmodule

`default_nettype wire

// ==== window_filter_chk.sv ====
/*
  four-phase rules on both links of window_filter_top, and output levels
  during reset; attached to the top level with bind
*/
`timescale 1ns/1ns
`default_nettype none

module window_filter_chk (
  input wire                     clk,
  input wire                     rst_n,
  input wire                     in_req,
  input wire                     in_ack,
  input wire                     out_req,
  input wire                     out_ack,
  input wire window_pkg::pixel_t out_data
);

  int assert_fail_count = 0;

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_req && !out_ack |=> out_req)
  else begin
    assert_fail_count++;
    $error("out_req dropped before out_ack was seen");
  end

  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_req && $past(out_req) |-> $stable(out_data))
  else begin
    assert_fail_count++;
    $error("out_data changed while out_req was high");
  end

  // ack rises one edge after req was sampled high
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(in_ack) |-> $past(in_req))
  else begin
    assert_fail_count++;
    $error("in_ack rose without in_req");
  end

  a_reset_low: assert property (@(posedge clk)
    !rst_n |-> !in_ack && !out_req)
  else begin
    assert_fail_count++;
    $error("in_ack or out_req high during reset");
  end

endmodule

bind window_filter_top window_filter_chk u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .in_req  (in_req),
  .in_ack  (in_ack),
  .out_req (out_req),
  .out_ack (out_ack),
  .out_data(out_data)
);

`default_nettype wire

// ==== tb_window_filter.sv ====
/*
  directed testbench for window_filter_top with a six-pixel line
  results are compared in raster order with a model of the 3x3 rules
  every frame starts with in_sof, since the DUT keeps rows across frames
*/
`timescale 1ns/1ns
`default_nettype none

module tb_window_filter;

  localparam int line_w = 6;
  localparam int rows = 4;
  // six full frames plus the restart test
  localparam int total_pixels = 6 * line_w * rows + 5 * line_w + 2;
  localparam int timeout_cycles = 40 * total_pixels + 200;

  logic                   clk;
  logic                   rst_n;
  logic                   in_req;
  logic                   in_sof;
  logic                   in_ack;
  logic                   out_req;
  logic                   out_ack;
  window_pkg::pixel_t     in_data;
  window_pkg::pixel_t     out_data;
  window_pkg::filter_op_e in_op;
  window_pkg::pixel_t     frame [$];
  window_pkg::pixel_t     got_q [$];
  window_pkg::pixel_t     exp_q [$];
  logic [31:0]            lfsr_state;
  int                     error_count;
  int                     ack_delay;
  int                     cycle_cnt;

  window_filter_top #(
    .line_width(line_w)
  ) u_dut (
    .clk(clk), .rst_n(rst_n),
    .in_req(in_req), .in_sof(in_sof), .in_data(in_data), .in_op(in_op),
    .out_ack(out_ack), .in_ack(in_ack), .out_req(out_req), .out_data(out_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic window_pkg::pixel_t random_pixel();
    window_pkg::pixel_t p;
    p = '0;
    for (int i = 0; i < window_pkg::pixel_w; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      p = {p[window_pkg::pixel_w-2:0], lfsr_state[0]};
    end
    return p;
  endfunction

  function automatic int kernel_weight(input int i);
    return (i == 1) ? 2 : 1;
  endfunction

  function automatic int px(input int r, input int c);
    return int'(frame[r * line_w + c]);
  endfunction

  // (r, c) is the newest pixel of the window, the centre is (r-1, c-1)
  function automatic window_pkg::pixel_t model_result(input window_pkg::filter_op_e op,
                                                      input int r, input int c);
    int sum;
    int gx;
    int gy;
    sum = 0;
    gx = 0;
    gy = 0;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        sum += kernel_weight(i) * kernel_weight(j) * px(r - 2 + i, c - 2 + j);
      end
      gx += kernel_weight(i) * (px(r - 2 + i, c) - px(r - 2 + i, c - 2));
      gy += kernel_weight(i) * (px(r, c - 2 + i) - px(r - 2, c - 2 + i));
    end
    gx = (gx < 0) ? -gx : gx;
    gy = (gy < 0) ? -gy : gy;
    case (op)
      window_pkg::op_smooth: return window_pkg::pixel_t'(sum / 16);
      window_pkg::op_sobel:  return (gx + gy > 255) ? 8'd255 : window_pkg::pixel_t'(gx + gy);
      default:               return frame[(r - 1) * line_w + c - 1];
    endcase
  endfunction

  task automatic expect_model(input window_pkg::filter_op_e op, input int n_rows);
    for (int r = 2; r < n_rows; r++) begin
      for (int c = 2; c < line_w; c++) begin
        exp_q.push_back(model_result(op, r, c));
      end
    end
  endtask

  task automatic fill_random(input int n_rows);
    frame.delete();
    repeat (n_rows * line_w) frame.push_back(random_pixel());
  endtask

  task automatic fill_const(input int n_rows, input window_pkg::pixel_t v);
    frame.delete();
    repeat (n_rows * line_w) frame.push_back(v);
  endtask

  // dark left half, bright right half
  task automatic fill_step(input int n_rows);
    frame.delete();
    for (int i = 0; i < n_rows * line_w; i++) begin
      frame.push_back((i % line_w >= 3) ? 8'd255 : 8'd0);
    end
  endtask

  task automatic check_pixel(input window_pkg::pixel_t got, input window_pkg::pixel_t exp,
                             input string what);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic send_pixel(input window_pkg::pixel_t p, input logic sof,
                            input window_pkg::filter_op_e op);
    in_data = p;
    in_sof = sof;
    in_op = op;
    in_req = 1'b1;
    do @(negedge clk); while (!in_ack);
    in_req = 1'b0;
    do @(negedge clk); while (in_ack);
    in_sof = 1'b0;
  endtask

  task automatic send_frame(input window_pkg::filter_op_e op, input int n);
    for (int i = 0; i < n; i++) begin
      send_pixel(frame[i], i == 0, op);
    end
  endtask

  // output side, acks each result after ack_delay cycles
  task automatic collect_results();
    forever begin
      @(negedge clk);
      if (out_req && !out_ack) begin
        repeat (ack_delay) @(negedge clk);
        got_q.push_back(out_data);
        out_ack = 1'b1;
        do @(negedge clk); while (out_req);
        out_ack = 1'b0;
      end
    end
  endtask

  task automatic watch_input();
    forever begin
      @(negedge clk);
      if (in_ack && out_req) begin
        error_count++;
        $display("at %0t ns a pixel was taken while a result was still waiting", $time);
      end
    end
  endtask

  // wait for n results, then for both links to go quiet
  task automatic wait_drain(input int n);
    int quiet;
    while (got_q.size() < n) @(negedge clk);
    quiet = 0;
    while (quiet < 4) begin
      @(negedge clk);
      quiet = (out_req || out_ack || in_ack) ? 0 : quiet + 1;
    end
  endtask

  task automatic compare_results(input string what);
    check_count(got_q.size(), exp_q.size(), what);
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      check_pixel(got_q[i], exp_q[i], $sformatf("%s result %0d", what, i));
    end
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic run_frame(input window_pkg::filter_op_e op, input int n_rows,
                           input string what);
    send_frame(op, n_rows * line_w);
    wait_drain(exp_q.size());
    compare_results(what);
  endtask

  task automatic test_reset();
    repeat (4) begin
      @(negedge clk);
      check_bit(in_ack, 1'b0, "in_ack after reset");
      check_bit(out_req, 1'b0, "out_req after reset");
    end
    check_count(got_q.size(), 0, "results before any pixel");
  endtask

  task automatic test_pass();
    fill_random(rows);
    expect_model(window_pkg::op_pass, rows);
    run_frame(window_pkg::op_pass, rows, "pass");
  endtask

  // same frame as the pass test, then a flat white frame
  task automatic test_smooth();
    expect_model(window_pkg::op_smooth, rows);
    run_frame(window_pkg::op_smooth, rows, "smooth");
    fill_const(rows, 8'd255);
    repeat ((line_w - 2) * (rows - 2)) exp_q.push_back(8'd255);
    run_frame(window_pkg::op_smooth, rows, "smooth white");
  endtask

  task automatic test_sobel();
    fill_step(rows);
    // windows ending at columns 3 and 4 straddle the step
    for (int r = 2; r < rows; r++) begin
      for (int c = 2; c < line_w; c++) begin
        exp_q.push_back((c == 3 || c == 4) ? 8'd255 : 8'd0);
      end
    end
    run_frame(window_pkg::op_sobel, rows, "sobel step");
    fill_random(rows);
    expect_model(window_pkg::op_sobel, rows);
    run_frame(window_pkg::op_sobel, rows, "sobel random");
  endtask

  task automatic test_backpressure();
    fill_random(rows);
    expect_model(window_pkg::op_smooth, rows);
    ack_delay = 20;
    run_frame(window_pkg::op_smooth, rows, "back-pressure");
    ack_delay = 0;
  endtask

  // two rows and two pixels, then a new frame that must start at row 0
  task automatic test_sof_restart();
    fill_random(3);
    send_frame(window_pkg::op_pass, 2 * line_w + 2);
    wait_drain(0);
    check_count(got_q.size(), 0, "partial frame");
    fill_random(3);
    expect_model(window_pkg::op_pass, 3);
    run_frame(window_pkg::op_pass, 3, "restart");
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    in_req = 1'b0;
    in_sof = 1'b0;
    in_data = '0;
    in_op = window_pkg::op_pass;
    out_ack = 1'b0;
    lfsr_state = 32'h158d_e0fa;
    error_count = 0;
    ack_delay = 0;
    fork
      collect_results();
      watch_input();
    join_none
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_pass();
    test_smooth();
    test_sobel();
    test_backpressure();
    test_sof_restart();
    error_count += u_dut.u_chk.assert_fail_count;
    $display("run complete with %0d errors", error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
window_pkg.sv
pixel_rx.sv
line_buffer.sv
line_window.sv
window_op.sv
window_filter_top.sv
window_filter_chk.sv
tb_window_filter.sv

// ==== Bender.yml ====
package:
  name: window_filter

sources:
  - window_pkg.sv
  - pixel_rx.sv
  - line_buffer.sv
  - line_window.sv
  - window_op.sv
  - window_filter_top.sv
  - target: test
    files:
      - window_filter_chk.sv
      - tb_window_filter.sv
